//--- verilog/net_pkg.sv
`default_nettype none

package net_pkg;

	//////////////////////////////////////////////////
	// Layer 2 and layer 3 address types

	// IPv4 address, network byte order in bits 31..24 first
	typedef logic [31:0] ip_addr_t;

	// Ethernet MAC address
	typedef logic [47:0] mac_addr_t;

	// All-ones MAC, used when an address is unknown
	localparam mac_addr_t BROADCAST_MAC = 48'hff_ff_ff_ff_ff_ff;

endpackage

`default_nettype wire

//--- verilog/arp_cache_pkg.sv
`default_nettype none

package arp_cache_pkg;

	//////////////////////////////////////////////////
	// Cache entry layout

	// Time since the entry was last learned or used, in aging ticks
	typedef logic [14:0] age_t;

	// Counter stops here instead of wrapping
	localparam age_t AGE_SATURATE = 15'h7fff;

	// Stored entry, 95 bits
	// The valid flag is kept in a separate register array
	typedef struct packed {
		age_t              age;
		net_pkg::ip_addr_t  ip;
		net_pkg::mac_addr_t mac;
	} arp_entry_t;

	//////////////////////////////////////////////////
	// Operation handed from request queue to engine

	typedef enum logic [1:0] {
		OP_NONE   = 2'd0,
		OP_LOOKUP = 2'd1,
		OP_LEARN  = 2'd2,
		OP_AGE    = 2'd3
	} arp_op_t;

endpackage

`default_nettype wire

//--- verilog/arp_request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module arp_request_queue #(
	parameter int LINES_PER_WAY = 128,
	localparam int LINE_BITS = $clog2(LINES_PER_WAY)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   lookup_en,
	input  net_pkg::ip_addr_t      lookup_ip,
	input  logic                   learn_en,
	input  net_pkg::ip_addr_t      learn_ip,
	input  net_pkg::mac_addr_t     learn_mac,
	input  logic                   aging_tick,
	input  logic                   grant,
	input  logic                   age_pass_done,
	output arp_cache_pkg::arp_op_t op,
	output net_pkg::ip_addr_t      op_ip,
	output net_pkg::mac_addr_t     op_mac,
	output logic [LINE_BITS-1:0]   op_line
);
	import net_pkg::*;
	import arp_cache_pkg::*;

	logic                 lookup_pending;
	ip_addr_t             lookup_ip_q;
	logic [LINE_BITS-1:0] lookup_line_q;

	logic                 learn_pending;
	ip_addr_t             learn_ip_q;
	mac_addr_t            learn_mac_q;
	logic [LINE_BITS-1:0] learn_line_q;

	// Set by a tick, held until the engine has walked the whole table
	logic                 age_pending;

	// Low bits of the byte sum folded with the low half select the line
	function automatic logic [LINE_BITS-1:0] line_hash(input ip_addr_t ip);
		logic [31:0] sum;
		sum = 32'(ip[7:0]) + 32'(ip[15:8]) + 32'(ip[23:16]) + 32'(ip[31:24]);
		sum = sum ^ {16'h0000, ip[15:0]};
		return sum[LINE_BITS-1:0];
	endfunction

	//////////////////////////////////////////////////
	// Pending flags

	always_ff @(posedge clk) begin
		if (rst) begin
			lookup_pending <= 1'b0;
			learn_pending  <= 1'b0;
			age_pending    <= 1'b0;
		end else begin
			// A request arriving while its slot is full is dropped
			if (grant && op == OP_LOOKUP)
				lookup_pending <= 1'b0;
			else if (lookup_en)
				lookup_pending <= 1'b1;

			if (grant && op == OP_LEARN)
				learn_pending <= 1'b0;
			else if (learn_en)
				learn_pending <= 1'b1;

			// New tick wins over the end of the current pass
			if (aging_tick)
				age_pending <= 1'b1;
			else if (age_pass_done)
				age_pending <= 1'b0;
		end
	end

	// Request payload is hashed on capture
	always_ff @(posedge clk) begin
		if (lookup_en && !lookup_pending) begin
			lookup_ip_q   <= lookup_ip;
			lookup_line_q <= line_hash(lookup_ip);
		end
		if (learn_en && !learn_pending) begin
			learn_ip_q   <= learn_ip;
			learn_mac_q  <= learn_mac;
			learn_line_q <= line_hash(learn_ip);
		end
	end

	//////////////////////////////////////////////////
	// Priority select in the order lookup, learn, age

	always_comb begin
		op      = OP_NONE;
		op_ip   = learn_ip_q;
		op_line = learn_line_q;
		if (lookup_pending) begin
			op      = OP_LOOKUP;
			op_ip   = lookup_ip_q;
			op_line = lookup_line_q;
		end else if (learn_pending) begin
			op = OP_LEARN;
		end else if (age_pending) begin
			op = OP_AGE;
		end
	end

	// MAC only matters for a learn
	assign op_mac = learn_mac_q;

	// A request taken into a free slot is offered from the next cycle on
	a_op_offered: assert property (@(posedge clk) disable iff (rst)
		((lookup_en && !lookup_pending) || (learn_en && !learn_pending) || aging_tick)
		|=> op != OP_NONE);

endmodule

`default_nettype wire

//--- verilog/arp_table.sv
`timescale 1ns/1ps
`default_nettype none

module arp_table #(
	parameter int LINES_PER_WAY = 128,
	parameter int NUM_WAYS = 4,
	localparam int ENTRIES = LINES_PER_WAY * NUM_WAYS,
	localparam int ADDR_BITS = $clog2(ENTRIES)
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rd_en,
	input  logic [ADDR_BITS-1:0]      rd_addr,
	input  logic                      wr_en,
	input  logic [ADDR_BITS-1:0]      wr_addr,
	input  logic                      wr_valid,
	input  arp_cache_pkg::arp_entry_t wr_data,
	output arp_cache_pkg::arp_entry_t rd_data,
	output logic                      rd_valid,
	output logic [ADDR_BITS-1:0]      rd_data_addr
);
	import arp_cache_pkg::*;

	// Address is {line, way}
	arp_entry_t           mem [ENTRIES];
	logic [ENTRIES-1:0]   valid_q;

	// First read stage
	arp_entry_t           rd_raw;
	logic                 rd_raw_valid;
	logic [ADDR_BITS-1:0] rd_raw_addr;

	// Entry RAM, registered read then output register
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en) begin
			rd_raw       <= mem[rd_addr];
			rd_raw_valid <= valid_q[rd_addr];
			rd_raw_addr  <= rd_addr;
		end
		rd_data      <= rd_raw;
		rd_valid     <= rd_raw_valid;
		rd_data_addr <= rd_raw_addr;
	end

	// Valid bits, empty table after reset
	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else if (wr_en)
			valid_q[wr_addr] <= wr_valid;
	end

	// Engine must never read an entry while it rewrites it
	a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
		!(rd_en && wr_en && rd_addr == wr_addr));

endmodule

`default_nettype wire

//--- verilog/arp_victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module arp_victim_select #(
	parameter int LINES_PER_WAY = 128,
	parameter int NUM_WAYS = 4,
	localparam int ADDR_BITS = $clog2(LINES_PER_WAY * NUM_WAYS)
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clear,
	input  logic                 sample,
	input  logic                 sample_valid,
	input  arp_cache_pkg::age_t  sample_age,
	input  logic [ADDR_BITS-1:0] sample_addr,
	output logic [ADDR_BITS-1:0] victim_addr
);
	import arp_cache_pkg::*;

	age_t best_age;
	// An empty way was seen, valid ways no longer qualify
	logic found_empty;

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			found_empty <= 1'b0;
			best_age    <= '0;
		end else if (sample) begin
			if (!sample_valid) begin
				// Later empty way overrides, so the highest one wins
				found_empty <= 1'b1;
				victim_addr <= sample_addr;
			end else if (!found_empty && sample_age >= best_age) begin
				// Oldest valid way, ties go to the later way
				best_age    <= sample_age;
				victim_addr <= sample_addr;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/arp_cache_engine.sv
`timescale 1ns/1ps
`default_nettype none

module arp_cache_engine #(
	parameter int LINES_PER_WAY = 128,
	parameter int NUM_WAYS = 4,
	localparam int LINE_BITS = $clog2(LINES_PER_WAY),
	localparam int WAY_BITS = $clog2(NUM_WAYS),
	localparam int ADDR_BITS = LINE_BITS + WAY_BITS
) (
	input  logic                      clk,
	input  logic                      rst,
	input  arp_cache_pkg::arp_op_t    op,
	input  net_pkg::ip_addr_t         op_ip,
	input  net_pkg::mac_addr_t        op_mac,
	input  logic [LINE_BITS-1:0]      op_line,
	input  arp_cache_pkg::age_t       max_age,
	input  arp_cache_pkg::arp_entry_t rd_data,
	input  logic                      rd_valid,
	input  logic [ADDR_BITS-1:0]      rd_data_addr,
	input  logic [ADDR_BITS-1:0]      victim_addr,
	output logic                      grant,
	output logic                      age_pass_done,
	output logic                      rd_en,
	output logic [ADDR_BITS-1:0]      rd_addr,
	output logic                      wr_en,
	output logic [ADDR_BITS-1:0]      wr_addr,
	output logic                      wr_valid,
	output arp_cache_pkg::arp_entry_t wr_data,
	output logic                      clear,
	output logic                      sample,
	output logic                      sample_valid,
	output arp_cache_pkg::age_t       sample_age,
	output logic [ADDR_BITS-1:0]      sample_addr,
	output logic                      finish,
	output logic                      hit,
	output net_pkg::mac_addr_t        hit_mac
);
	import net_pkg::*;
	import arp_cache_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WALK,
		S_VICTIM,
		S_AGE_WAIT,
		S_AGE_WB
	} state_t;

	state_t               state;
	arp_op_t              cur_op;
	ip_addr_t             tgt_ip;
	mac_addr_t            tgt_mac;
	logic [LINE_BITS-1:0] tgt_line;
	// Reads issued in this walk
	// MSB is set once all ways are out
	logic [WAY_BITS:0]    issue_cnt;
	// Bit 1 of the read pipeline tracker marks rd_data of this walk
	logic [1:0]           pend;
	logic [ADDR_BITS-1:0] age_addr;

	logic data_ok;
	logic ip_match;
	logic last_way;
	age_t aged;

	//////////////////////////////////////////////////
	// Hit detection and handshakes

	assign grant    = (state == S_IDLE) && (op != OP_NONE);
	assign data_ok  = (state == S_WALK) && pend[1];
	assign ip_match = data_ok && rd_valid && (rd_data.ip == tgt_ip);
	assign last_way = data_ok && (rd_data_addr[WAY_BITS-1:0] == '1);

	// Lookup result goes out the cycle the walk ends
	assign finish  = (cur_op == OP_LOOKUP) && (ip_match || last_way);
	assign hit     = ip_match;
	assign hit_mac = rd_data.mac;

	// Replacement tracking during a learn walk
	assign clear        = grant && (op == OP_LEARN);
	assign sample       = data_ok && (cur_op == OP_LEARN) && !ip_match;
	assign sample_valid = rd_valid;
	assign sample_age   = rd_data.age;
	assign sample_addr  = rd_data_addr;

	// Last table entry written back
	assign age_pass_done = (state == S_AGE_WB) && (age_addr == '1);
	assign aged = (rd_data.age == AGE_SATURATE) ? AGE_SATURATE : rd_data.age + 1'b1;

	//////////////////////////////////////////////////
	// Read and write ports

	always_comb begin
		rd_en   = 1'b0;
		rd_addr = {tgt_line, issue_cnt[WAY_BITS-1:0]};
		if (grant) begin
			// First read goes out together with the grant
			rd_en   = 1'b1;
			rd_addr = (op == OP_AGE) ? age_addr : {op_line, {WAY_BITS{1'b0}}};
		end else if (state == S_WALK) begin
			rd_en = !issue_cnt[WAY_BITS];
		end
	end

	always_comb begin
		wr_en    = 1'b0;
		wr_addr  = rd_data_addr;
		wr_valid = 1'b1;
		wr_data  = rd_data;
		case (state)
			S_WALK: begin
				// A match refreshes the age and a learn also takes the new MAC
				if (ip_match) begin
					wr_en       = 1'b1;
					wr_data.age = '0;
					if (cur_op == OP_LEARN)
						wr_data.mac = tgt_mac;
				end
			end
			S_VICTIM: begin
				wr_en       = 1'b1;
				wr_addr     = victim_addr;
				wr_data.age = '0;
				wr_data.ip  = tgt_ip;
				wr_data.mac = tgt_mac;
			end
			S_AGE_WB: begin
				// Empty entries stay untouched
				wr_en = rd_valid;
				if (rd_data.age > max_age)
					wr_valid = 1'b0;
				else
					wr_data.age = aged;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			cur_op    <= OP_NONE;
			issue_cnt <= '0;
			pend      <= '0;
			age_addr  <= '0;
		end else begin
			pend <= {pend[0], rd_en};
			case (state)
				S_IDLE: begin
					if (grant) begin
						cur_op    <= op;
						issue_cnt <= (WAY_BITS+1)'(1);
						state     <= (op == OP_AGE) ? S_AGE_WAIT : S_WALK;
					end
				end
				S_WALK: begin
					if (rd_en)
						issue_cnt <= issue_cnt + 1'b1;
					if (ip_match) begin
						// Drop reads still in flight for later ways
						pend  <= '0;
						state <= S_IDLE;
					end else if (last_way) begin
						state <= (cur_op == OP_LEARN) ? S_VICTIM : S_IDLE;
					end
				end
				S_VICTIM:
					state <= S_IDLE;
				S_AGE_WAIT:
					state <= S_AGE_WB;
				S_AGE_WB: begin
					// Back to idle so lookups and learns can cut in
					age_addr <= age_addr + 1'b1;
					state    <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Target of the current walk
	always_ff @(posedge clk) begin
		if (grant) begin
			tgt_ip   <= op_ip;
			tgt_mac  <= op_mac;
			tgt_line <= op_line;
		end
	end

	a_finish_pulse: assert property (@(posedge clk) disable iff (rst)
		finish |=> !finish);

	// New work only starts once no read of the previous operation is tracked
	a_grant_idle: assert property (@(posedge clk) disable iff (rst)
		grant |-> pend == '0);

endmodule

`default_nettype wire

//--- verilog/arp_lookup_response.sv
`timescale 1ns/1ps
`default_nettype none

module arp_lookup_response (
	input  logic               clk,
	input  logic               rst,
	input  logic               finish,
	input  logic               hit,
	input  net_pkg::mac_addr_t hit_mac,
	output logic               lookup_done,
	output logic               lookup_hit,
	output net_pkg::mac_addr_t lookup_mac
);
	import net_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			lookup_done <= 1'b0;
			lookup_hit  <= 1'b0;
			lookup_mac  <= BROADCAST_MAC;
		end else begin
			lookup_done <= finish;
			// Result is held until the next lookup completes
			if (finish) begin
				lookup_hit <= hit;
				// Unknown address resolves to broadcast
				lookup_mac <= hit ? hit_mac : BROADCAST_MAC;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/arp_cache.sv
`timescale 1ns/1ps
`default_nettype none

module arp_cache #(
	parameter int LINES_PER_WAY = 128,
	parameter int NUM_WAYS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                lookup_en,
	input  net_pkg::ip_addr_t   lookup_ip,
	output logic                lookup_done,
	output logic                lookup_hit,
	output net_pkg::mac_addr_t  lookup_mac,
	input  logic                learn_en,
	input  net_pkg::ip_addr_t   learn_ip,
	input  net_pkg::mac_addr_t  learn_mac,
	input  logic                aging_tick,
	// Entries older than this are dropped on the next aging pass
	input  arp_cache_pkg::age_t max_age
);
	import net_pkg::*;
	import arp_cache_pkg::*;

	localparam int LINE_BITS = $clog2(LINES_PER_WAY);
	localparam int ADDR_BITS = $clog2(LINES_PER_WAY * NUM_WAYS);

	//////////////////////////////////////////////////
	// Queue to engine
	arp_op_t              op;
	ip_addr_t             op_ip;
	mac_addr_t            op_mac;
	logic [LINE_BITS-1:0] op_line;
	logic                 grant;
	logic                 age_pass_done;

	// Engine to table
	logic                 rd_en;
	logic [ADDR_BITS-1:0] rd_addr;
	arp_entry_t           rd_data;
	logic                 rd_valid;
	logic [ADDR_BITS-1:0] rd_data_addr;
	logic                 wr_en;
	logic [ADDR_BITS-1:0] wr_addr;
	logic                 wr_valid;
	arp_entry_t           wr_data;

	// Engine to victim select
	logic                 clear;
	logic                 sample;
	logic                 sample_valid;
	age_t                 sample_age;
	logic [ADDR_BITS-1:0] sample_addr;
	logic [ADDR_BITS-1:0] victim_addr;

	// Engine to response
	logic                 finish;
	logic                 hit;
	mac_addr_t            hit_mac;

	arp_request_queue #(
		.LINES_PER_WAY(LINES_PER_WAY)
	) u_queue (
		.clk(clk), .rst(rst),
		.lookup_en(lookup_en), .lookup_ip(lookup_ip),
		.learn_en(learn_en), .learn_ip(learn_ip), .learn_mac(learn_mac),
		.aging_tick(aging_tick), .grant(grant), .age_pass_done(age_pass_done),
		.op(op), .op_ip(op_ip), .op_mac(op_mac), .op_line(op_line)
	);

	arp_cache_engine #(
		.LINES_PER_WAY(LINES_PER_WAY),
		.NUM_WAYS(NUM_WAYS)
	) u_engine (
		.clk(clk), .rst(rst),
		.op(op), .op_ip(op_ip), .op_mac(op_mac), .op_line(op_line), .max_age(max_age),
		.rd_data(rd_data), .rd_valid(rd_valid), .rd_data_addr(rd_data_addr),
		.victim_addr(victim_addr), .grant(grant), .age_pass_done(age_pass_done),
		.rd_en(rd_en), .rd_addr(rd_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_valid(wr_valid), .wr_data(wr_data),
		.clear(clear), .sample(sample), .sample_valid(sample_valid),
		.sample_age(sample_age), .sample_addr(sample_addr),
		.finish(finish), .hit(hit), .hit_mac(hit_mac)
	);

	arp_table #(
		.LINES_PER_WAY(LINES_PER_WAY),
		.NUM_WAYS(NUM_WAYS)
	) u_table (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_valid(wr_valid), .wr_data(wr_data),
		.rd_data(rd_data), .rd_valid(rd_valid), .rd_data_addr(rd_data_addr)
	);

	arp_victim_select #(
		.LINES_PER_WAY(LINES_PER_WAY),
		.NUM_WAYS(NUM_WAYS)
	) u_victim (
		.clk(clk), .rst(rst),
		.clear(clear), .sample(sample), .sample_valid(sample_valid),
		.sample_age(sample_age), .sample_addr(sample_addr),
		.victim_addr(victim_addr)
	);

	arp_lookup_response u_response (
		.clk(clk), .rst(rst),
		.finish(finish), .hit(hit), .hit_mac(hit_mac),
		.lookup_done(lookup_done), .lookup_hit(lookup_hit), .lookup_mac(lookup_mac)
	);

endmodule

`default_nettype wire

//--- tb/arp_cache_model.svh
`ifndef ARP_CACHE_MODEL_SVH
`define ARP_CACHE_MODEL_SVH

//////////////////////////////////////////////////
// Reference table, indexed [line][way]

bit          tbl_valid [TB_LINES][TB_WAYS];
ip_addr_t    tbl_ip    [TB_LINES][TB_WAYS];
mac_addr_t   tbl_mac   [TB_LINES][TB_WAYS];
// Ticks since last learn or hit
int unsigned tbl_age   [TB_LINES][TB_WAYS];

// Sum of the four bytes, folded with the low half of the address
function automatic int hash_line(input ip_addr_t ip);
	logic [31:0] folded;
	folded = {24'h0, ip[31:24]} + {24'h0, ip[23:16]} + {24'h0, ip[15:8]} + {24'h0, ip[7:0]};
	folded = folded ^ {16'h0, ip[15:0]};
	return int'(folded % TB_LINES);
endfunction

// Empty table, as after reset
function automatic void clear_table();
	int line;
	int way;
	for (line = 0; line < TB_LINES; line++)
		for (way = 0; way < TB_WAYS; way++)
			tbl_valid[line][way] = 1'b0;
endfunction

// Way holding ip, or -1
function automatic int find_way(input int line, input ip_addr_t ip);
	int way;
	for (way = 0; way < TB_WAYS; way++)
		if (tbl_valid[line][way] && tbl_ip[line][way] == ip)
			return way;
	return -1;
endfunction

// Expected lookup result, a hit also resets the age
function automatic void lookup_expect(input ip_addr_t ip, output bit hit, output mac_addr_t mac);
	int line;
	int way;
	line = hash_line(ip);
	way  = find_way(line, ip);
	hit  = (way >= 0);
	mac  = BROADCAST_MAC;
	if (hit) begin
		mac = tbl_mac[line][way];
		tbl_age[line][way] = 0;
	end
endfunction

// Highest empty way first, then the oldest, higher way on equal age
function automatic int choose_victim(input int line);
	int way;
	int best;
	for (way = TB_WAYS - 1; way >= 0; way--)
		if (!tbl_valid[line][way])
			return way;
	best = TB_WAYS - 1;
	// Walking downward, only a strictly older way displaces the current pick
	for (way = TB_WAYS - 2; way >= 0; way--)
		if (tbl_age[line][way] > tbl_age[line][best])
			best = way;
	return best;
endfunction

// Refresh a known address or take over the victim way
function automatic void learn_apply(input ip_addr_t ip, input mac_addr_t mac);
	int line;
	int way;
	line = hash_line(ip);
	way  = find_way(line, ip);
	if (way < 0)
		way = choose_victim(line);
	tbl_valid[line][way] = 1'b1;
	tbl_ip[line][way]    = ip;
	tbl_mac[line][way]   = mac;
	tbl_age[line][way]   = 0;
endfunction

// One full aging pass
function automatic void age_table(input int unsigned limit);
	int line;
	int way;
	for (line = 0; line < TB_LINES; line++)
		for (way = 0; way < TB_WAYS; way++)
			if (tbl_valid[line][way]) begin
				if (tbl_age[line][way] > limit)
					tbl_valid[line][way] = 1'b0;
				else if (tbl_age[line][way] < AGE_SATURATE)
					tbl_age[line][way]++;
			end
endfunction

`endif

//--- tb/arp_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arp_cache_tb;
	import net_pkg::*;
	import arp_cache_pkg::*;

	localparam int TB_LINES = 8;
	localparam int TB_WAYS = 4;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;

	// Settling time per operation, in cycles
	localparam int LEARN_WAIT = 3 * (TB_WAYS + 6);
	localparam int LOOKUP_LIMIT = 2 * (TB_WAYS + 6);
	localparam int TICK_WAIT = 5 * TB_LINES * TB_WAYS;

	// Length of each test phase
	localparam int BOOT_LOOKUPS = 16;
	localparam int POOL_SIZE = 20;
	localparam int MIX_OPS = 300;
	localparam int COLLIDE_IPS = TB_WAYS + 2;
	localparam int COLLIDE_LINE = 5;
	localparam int AGE_ROUNDS = 4;

	// Upper bounds per operation kind over the whole run
	localparam int MAX_LEARNS = MIX_OPS + COLLIDE_IPS + AGE_ROUNDS + 1;
	localparam int MAX_LOOKUPS = BOOT_LOOKUPS + MIX_OPS + 2 * COLLIDE_IPS + AGE_ROUNDS + 4;
	localparam int MAX_TICKS = MIX_OPS + AGE_ROUNDS + 3;
	localparam int RUN_CYCLES = RESET_CYCLES + MAX_LEARNS * (LEARN_WAIT + 1)
		+ MAX_LOOKUPS * (LOOKUP_LIMIT + 1) + MAX_TICKS * TICK_WAIT + 10;

	logic      clk;
	logic      rst;
	logic      lookup_en;
	ip_addr_t  lookup_ip;
	logic      lookup_done;
	logic      lookup_hit;
	mac_addr_t lookup_mac;
	logic      learn_en;
	ip_addr_t  learn_ip;
	mac_addr_t learn_mac;
	logic      aging_tick;
	age_t      max_age;

	int checks = 0;
	int errors = 0;
	int lookups_issued = 0;
	int done_count = 0;

	`include "arp_cache_model.svh"

	arp_cache #(
		.LINES_PER_WAY(TB_LINES),
		.NUM_WAYS(TB_WAYS)
	) dut0 (
		.clk(clk), .rst(rst),
		.lookup_en(lookup_en), .lookup_ip(lookup_ip),
		.lookup_done(lookup_done), .lookup_hit(lookup_hit), .lookup_mac(lookup_mac),
		.learn_en(learn_en), .learn_ip(learn_ip), .learn_mac(learn_mac),
		.aging_tick(aging_tick), .max_age(max_age)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run length bound, twice the worst case of all phases
	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, run did not end within %0d cycles", 2 * RUN_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	// Every lookup must give exactly one done pulse
	always @(negedge clk) begin
		if (!rst && lookup_done)
			done_count++;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Returns 5 ns after the n-th rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// Locally administered, never all ones
	function automatic mac_addr_t random_mac();
		return {8'h02, 8'($urandom), $urandom};
	endfunction

	task automatic send_learn(input ip_addr_t ip, input mac_addr_t mac);
		learn_ip  = ip;
		learn_mac = mac;
		learn_en  = 1'b1;
		wait_cycles(1);
		learn_en = 1'b0;
		learn_apply(ip, mac);
		wait_cycles(LEARN_WAIT - 1);
	endtask

	// Second strobe lands while the first learn still holds the slot
	task automatic send_learn_pair(input ip_addr_t first_ip, input mac_addr_t first_mac,
		input ip_addr_t second_ip, input mac_addr_t second_mac);
		learn_ip  = first_ip;
		learn_mac = first_mac;
		learn_en  = 1'b1;
		wait_cycles(1);
		learn_ip  = second_ip;
		learn_mac = second_mac;
		wait_cycles(1);
		learn_en = 1'b0;
		// Only the first one reaches the table
		learn_apply(first_ip, first_mac);
		wait_cycles(LEARN_WAIT - 2);
	endtask

	task automatic send_lookup(input ip_addr_t ip);
		bit        exp_hit;
		mac_addr_t exp_mac;
		int        waited;
		lookup_expect(ip, exp_hit, exp_mac);
		lookup_ip = ip;
		lookup_en = 1'b1;
		lookups_issued++;
		wait_cycles(1);
		lookup_en = 1'b0;
		waited = 1;
		while (!lookup_done && waited < LOOKUP_LIMIT) begin
			wait_cycles(1);
			waited++;
		end
		if (lookup_done) begin
			check_value("lookup_hit", lookup_hit, exp_hit);
			check_value("lookup_mac", lookup_mac, exp_mac);
		end else begin
			errors++;
			$display("Lookup of IP %h gave no lookup_done within %0d cycles", ip, LOOKUP_LIMIT);
		end
	endtask

	// Threshold held as a level through the whole pass
	task automatic send_tick(input age_t limit);
		max_age    = limit;
		aging_tick = 1'b1;
		wait_cycles(1);
		aging_tick = 1'b0;
		age_table(limit);
		wait_cycles(TICK_WAIT - 1);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		ip_addr_t pool [POOL_SIZE];
		ip_addr_t group [COLLIDE_IPS];
		ip_addr_t cand;
		ip_addr_t stray;
		int       found;
		int       pick;
		int       k;

		void'($urandom(18716));
		rst        = 1'b1;
		lookup_en  = 1'b0;
		lookup_ip  = '0;
		learn_en   = 1'b0;
		learn_ip   = '0;
		learn_mac  = '0;
		aging_tick = 1'b0;
		max_age    = '0;
		clear_table();
		wait_cycles(RESET_CYCLES);
		rst = 1'b0;

		// Empty table, everything misses
		for (k = 0; k < BOOT_LOOKUPS; k++)
			send_lookup($urandom);

		// Small pool, so lines collide and relearns happen
		for (k = 0; k < POOL_SIZE; k++)
			pool[k] = {16'h0a00, 16'($urandom)};

		// Random mix of learn, lookup and tick
		for (k = 0; k < MIX_OPS; k++) begin
			pick = $urandom_range(0, 99);
			cand = pool[$urandom_range(0, POOL_SIZE - 1)];
			if (pick < 40)
				send_learn(cand, random_mac());
			else if (pick < 88)
				send_lookup(cand);
			else
				send_tick(age_t'($urandom_range(0, 3)));
		end

		// Two ticks at zero threshold empty the table
		send_tick(age_t'(0));
		send_tick(age_t'(0));

		// Addresses that all hash to one line
		found = 0;
		cand  = 32'hac10_0000;
		while (found < COLLIDE_IPS) begin
			if (hash_line(cand) == COLLIDE_LINE) begin
				group[found] = cand;
				found++;
			end
			cand++;
		end

		// Fill the line, age it, refresh two ways, then overflow it
		for (k = 0; k < TB_WAYS; k++)
			send_learn(group[k], random_mac());
		send_tick(age_t'(100));
		send_lookup(group[1]);
		send_lookup(group[2]);
		for (k = TB_WAYS; k < COLLIDE_IPS; k++)
			send_learn(group[k], random_mac());
		for (k = 0; k < COLLIDE_IPS; k++)
			send_lookup(group[k]);

		// Tight threshold, only the entries in use survive
		for (k = 0; k < AGE_ROUNDS; k++) begin
			send_tick(age_t'(1));
			send_lookup(group[1]);
			send_learn(group[2], random_mac());
		end
		for (k = 0; k < COLLIDE_IPS; k++)
			send_lookup(group[k]);

		// Back-to-back learns, the second one is lost
		stray = {16'hc0a8, 16'($urandom)};
		send_learn_pair(pool[0], random_mac(), stray, random_mac());
		send_lookup(pool[0]);
		send_lookup(stray);

		wait_cycles(4);
		check_value("lookup_done pulse count", done_count, lookups_issued);
		$display("Checks: %0d, errors: %0d, lookups: %0d", checks, errors, lookups_issued);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
verilog/net_pkg.sv
verilog/arp_cache_pkg.sv
verilog/arp_request_queue.sv
verilog/arp_table.sv
verilog/arp_victim_select.sv
verilog/arp_cache_engine.sv
verilog/arp_lookup_response.sv
verilog/arp_cache.sv
tb/arp_cache_tb.sv

//--- Makefile
TOP = arp_cache_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module arp_cache

clean:
	rm -rf obj_dir $(LOG)
